// File: Makefile
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_subsys
DUT_TOP   ?= periph_subsys
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/periph_pkg.sv
// Shared definitions for the 0x800000xx peripheral window
// Only register offset 0 of each slot is mapped, except slot 7 which is a raw byte window
// UART slots 0 and 1 are kept in the map but have no hardware behind them
package periph_pkg;

    // ==============================
    // Word widths
    // ==============================
    localparam int WORD_WIDTH = 32;        // Bus data and address width

    typedef logic [WORD_WIDTH-1:0] word_t; // Address and data word

    // ==============================
    // Access size, funct3[1:0]
    // ==============================
    // funct3[2] is the unsigned flag and is carried separately
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,                  // LB / LBU / SB
        SIZE_HALF = 2'd1,                  // LH / LHU / SH
        SIZE_WORD = 2'd2                   // LW / SW
    } access_size_e;

    // ==============================
    // Peripheral slots, addr[7:4]
    // ==============================
    typedef enum logic [3:0] {
        SLOT_UART0   = 4'd0,               // Unmapped here, reads 0
        SLOT_UART1   = 4'd1,               // Unmapped here, reads 0
        SLOT_I2C     = 4'd2,
        SLOT_GPIO    = 4'd3,
        SLOT_SPI     = 4'd4,
        SLOT_COUNTER = 4'd5,
        SLOT_EXT     = 4'd7                // External byte-lane window
    } periph_slot_e;

    // Window hit when addr[31:8] == 24'h800000
    localparam word_t PERIPH_WIN_BASE = 32'h8000_0000;
    localparam word_t PERIPH_WIN_MASK = 32'hFFFF_FF00;

    // Data register, addr[3:2]
    localparam logic [1:0] REG_OFFSET_DATA = 2'b00;

    // ==============================
    // Output register reset values
    // ==============================
    localparam word_t I2C_WR_RESET = 32'h0000_0003; // SCL and SDA released
    localparam word_t SPI_WR_RESET = 32'h0000_0000; // SCK and MOSI low

endpackage

// File: compile.f
common/periph_pkg.sv
source/periph_decode.sv
source/free_counter.sv
pins/pin_ctrl_regs.sv
pins/pin_drive.sv
ext_bus/ext_bus_align.sv
source/periph_read_path.sv
source/periph_subsys.sv
+incdir+verification
verification/tb_periph_subsys.sv

// File: ext_bus/ext_bus_align.sv
// Byte-lane steering for the external window, all combinational
// Half accesses at odd offsets raise no strobes; word accesses ignore the offset
// Read data must be valid in the address cycle; it is registered in the read path
`timescale 1ns/1ns

module ext_bus_align (
    input  logic [1:0]        addr_lo_i,     // addr[1:0], byte lane
    input  logic [2:0]        funct3_i,      // [2] unsigned, [1:0] size
    input  periph_pkg::word_t wdata_i,       // Right-aligned write data
    input  logic              wr_en_i,
    input  logic              ext_sel_i,     // Slot 7 hit
    input  periph_pkg::word_t ext_rddata_i,  // Lane-aligned read data
    output periph_pkg::word_t ext_wdata_o,   // Write data moved to its lane
    output logic [3:0]        ext_strb_o,
    output periph_pkg::word_t ext_rdata_o    // Right-aligned and extended
);
    import periph_pkg::*;

    access_size_e size;
    logic         is_unsigned;
    logic [4:0]   lane_shift;   // Byte offset in bits
    logic [3:0]   strb_raw;     // Before write and select gating
    word_t        rd_shifted;

    assign size        = access_size_e'(funct3_i[1:0]);
    assign is_unsigned = funct3_i[2];
    assign lane_shift  = {addr_lo_i, 3'b000};

    // ==============================
    // Write side
    // ==============================
    assign ext_wdata_o = wdata_i << lane_shift;   // Low bytes up to the lane

    always_comb begin
        case (size)
            SIZE_BYTE: strb_raw = 4'b0001 << addr_lo_i;
            SIZE_HALF: begin
                if (addr_lo_i[0]) begin
                    strb_raw = 4'b0000;            // Misaligned half
                end else begin
                    strb_raw = addr_lo_i[1] ? 4'b1100 : 4'b0011;
                end
            end
            SIZE_WORD: strb_raw = 4'b1111;
            default:   strb_raw = 4'b0000;         // funct3[1:0] == 3
        endcase
    end

    assign ext_strb_o = (wr_en_i && ext_sel_i) ? strb_raw : 4'b0000;

    // ==============================
    // Read side
    // ==============================
    assign rd_shifted = ext_rddata_i >> lane_shift;  // Lane down to bit 0

    always_comb begin
        case (size)
            SIZE_BYTE: ext_rdata_o = {{24{~is_unsigned & rd_shifted[7]}}, rd_shifted[7:0]};
            SIZE_HALF: ext_rdata_o = {{16{~is_unsigned & rd_shifted[15]}}, rd_shifted[15:0]};
            default:   ext_rdata_o = rd_shifted;  // Word and reserved size
        endcase
    end

endmodule

// File: pins/pin_ctrl_regs.sv
// Output value registers for the GPIO, I2C and SPI pins
// Whole-word writes only; the byte strobes of the bus are not used here
// GPIO_WIDTH must stay below 32
`timescale 1ns/1ns

module pin_ctrl_regs #(
    parameter int                    GPIO_WIDTH    = 4,
    parameter logic [GPIO_WIDTH-1:0] GPIO_WR_RESET = 2
) (
    input  logic                  clk_i,
    input  logic                  cpu_rst,
    input  periph_pkg::word_t     wdata_i,     // Bus write data
    input  logic                  gpio_wr_i,   // Strobes from decode
    input  logic                  i2c_wr_i,
    input  logic                  spi_wr_i,
    output logic [GPIO_WIDTH-1:0] gpio_out_o,
    output logic [1:0]            i2c_out_o,   // {sda, scl} with 1 released
    output logic [2:0]            spi_out_o    // {sck, mosi, miso}
);
    import periph_pkg::*;

    // ==============================
    // Pin output registers
    // ==============================
    always_ff @(posedge clk_i or posedge cpu_rst) begin
        if (cpu_rst) begin
            gpio_out_o <= GPIO_WR_RESET;
            i2c_out_o  <= I2C_WR_RESET[1:0];   // Bus idle with both lines high
            spi_out_o  <= SPI_WR_RESET[2:0];
        end else begin
            if (gpio_wr_i) begin
                gpio_out_o <= wdata_i[GPIO_WIDTH-1:0];
            end
            if (i2c_wr_i) begin
                i2c_out_o <= wdata_i[1:0];
            end
            if (spi_wr_i) begin
                spi_out_o <= wdata_i[2:0];     // Bit 0 stored though MISO stays input
            end
        end
    end

endmodule

// File: pins/pin_drive.sv
// Pad drive and enable from the output registers and fixed direction masks
// Pad inputs are registered every cycle, zero-padded to a word
// I2C pads only ever pull low; the pull-up is external
`timescale 1ns/1ns

module pin_drive #(
    parameter int                    GPIO_WIDTH    = 4,
    parameter logic [GPIO_WIDTH-1:0] GPIO_DIR_MASK = 3,  // 1 = output
    parameter logic [GPIO_WIDTH-1:0] GPIO_OD_MASK  = 2   // 1 = open drain
) (
    input  logic                  clk_i,
    input  logic                  cpu_rst,
    input  logic [GPIO_WIDTH-1:0] gpio_out_i,
    input  logic [1:0]            i2c_out_i,      // {sda, scl}
    input  logic [2:0]            spi_out_i,      // {sck, mosi, miso}
    input  logic [GPIO_WIDTH-1:0] gpio_i,
    input  logic                  scl_i,
    input  logic                  sda_i,
    input  logic                  miso_i,
    output logic [GPIO_WIDTH-1:0] gpio_o,
    output logic [GPIO_WIDTH-1:0] gpio_oe_o,
    output logic                  scl_oe_o,
    output logic                  sda_oe_o,
    output logic                  sck_o,
    output logic                  mosi_o,
    output periph_pkg::word_t     gpio_sample_o,
    output periph_pkg::word_t     i2c_sample_o,
    output periph_pkg::word_t     spi_sample_o
);
    import periph_pkg::*;

    localparam logic [2:0] SPI_DIR_MASK = 3'b110;  // SCK, MOSI out

    logic [2:0] spi_pad;    // Wire level per SPI line
    word_t      gpio_word;

    // Open-drain bits only enable the driver for a 0
    assign gpio_o    = gpio_out_i;
    assign gpio_oe_o = GPIO_DIR_MASK & ~(GPIO_OD_MASK & gpio_out_i);

    assign scl_oe_o = ~i2c_out_i[0];   // Pull low when written 0
    assign sda_oe_o = ~i2c_out_i[1];

    assign spi_pad = (spi_out_i & SPI_DIR_MASK) | ({2'b00, miso_i} & ~SPI_DIR_MASK);
    assign sck_o   = spi_pad[2];
    assign mosi_o  = spi_pad[1];

    always_comb begin
        gpio_word                   = '0;
        gpio_word[GPIO_WIDTH-1:0]   = gpio_i;
    end

    // ==============================
    // Pad sample registers
    // ==============================
    always_ff @(posedge clk_i or posedge cpu_rst) begin
        if (cpu_rst) begin
            gpio_sample_o <= '0;
            i2c_sample_o  <= '0;
            spi_sample_o  <= '0;
        end else begin
            gpio_sample_o <= gpio_word;
            i2c_sample_o  <= {30'b0, sda_i, scl_i};
            spi_sample_o  <= {29'b0, spi_pad};
        end
    end

    // Open-drain GPIO never drives a high level onto the pad
    assert property (@(posedge clk_i) disable iff (cpu_rst)
        (gpio_oe_o & gpio_o & GPIO_OD_MASK) == '0);

endmodule

// File: source/free_counter.sv
// Free-running 32-bit cycle counter that wraps at all ones
// A load takes the written value; counting resumes from it on the next cycle
`timescale 1ns/1ns

module free_counter (
    input  logic              clk_i,
    input  logic              cpu_rst,
    input  logic              load_i,        // Counter register written
    input  periph_pkg::word_t load_value_i,  // Write data
    output periph_pkg::word_t count_o
);
    import periph_pkg::*;

    word_t count_q;

    always_ff @(posedge clk_i or posedge cpu_rst) begin
        if (cpu_rst) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_value_i;
        end else begin
            count_q <= count_q + 1'b1;            // Wraps naturally
        end
    end

    assign count_o = count_q;

    // Steady count when left alone and across the wrap from all ones
    assert property (@(posedge clk_i) disable iff (cpu_rst)
        !$past(load_i) && !$past(cpu_rst) |-> count_o == $past(count_o) + 1'b1);

endmodule

// File: source/periph_decode.sv
// Address decode for the peripheral window
// Write strobes need the data offset; the external slot ignores the offset
// Address phase only, no handshake, purely combinational
`timescale 1ns/1ns

module periph_decode (
    input  periph_pkg::word_t        addr_i,      // Address phase address
    input  logic                     wr_en_i,     // Address phase write
    output periph_pkg::periph_slot_e rd_slot_o,   // Read source select
    output logic                     rd_hit_o,    // Read lands on a mapped location
    output logic                     ext_sel_o,   // Slot 7 selected
    output logic [3:0]               ext_addr_o,  // Byte address inside slot 7
    output logic                     i2c_wr_o,
    output logic                     gpio_wr_o,
    output logic                     spi_wr_o,
    output logic                     counter_wr_o
);
    import periph_pkg::*;

    logic         win_hit;   // addr in 0x800000xx
    logic         data_off;  // addr[3:2] on data register
    periph_slot_e slot;

    assign win_hit  = (addr_i & PERIPH_WIN_MASK) == PERIPH_WIN_BASE;
    assign slot     = periph_slot_e'(addr_i[7:4]);
    assign data_off = (addr_i[3:2] == REG_OFFSET_DATA);

    // Read selection, unmapped slots are zeroed in the read path
    assign rd_slot_o  = slot;
    assign rd_hit_o   = win_hit && (data_off || slot == SLOT_EXT);
    assign ext_sel_o  = win_hit && (slot == SLOT_EXT);
    assign ext_addr_o = addr_i[3:0];

    // ==============================
    // Write strobes
    // ==============================
    always_comb begin
        i2c_wr_o     = 1'b0;
        gpio_wr_o    = 1'b0;
        spi_wr_o     = 1'b0;
        counter_wr_o = 1'b0;
        if (win_hit && data_off && wr_en_i) begin
            case (slot)
                SLOT_I2C:     i2c_wr_o     = 1'b1;
                SLOT_GPIO:    gpio_wr_o    = 1'b1;
                SLOT_SPI:     spi_wr_o     = 1'b1;
                SLOT_COUNTER: counter_wr_o = 1'b1;
                default:      ;                    // UART and slot 6 drop writes
            endcase
        end
        // Never more than one register block written per access
        assert ($onehot0({i2c_wr_o, gpio_wr_o, spi_wr_o, counter_wr_o}))
            else $error("periph_decode: more than one write strobe");
    end

endmodule

// File: source/periph_read_path.sv
// Read-back mux with one cycle of registered latency
// Misses and unmapped slots (UART0, UART1, slot 6) return 0
// Reads have no side effects on any source
`timescale 1ns/1ns

module periph_read_path (
    input  logic                     clk_i,
    input  logic                     cpu_rst,
    input  periph_pkg::periph_slot_e rd_slot_i,      // Slot of the address phase
    input  logic                     rd_hit_i,       // Window and offset matched
    input  periph_pkg::word_t        counter_i,      // Live counter value
    input  periph_pkg::word_t        gpio_sample_i,  // Registered pad words
    input  periph_pkg::word_t        i2c_sample_i,
    input  periph_pkg::word_t        spi_sample_i,
    input  periph_pkg::word_t        ext_rdata_i,    // Aligned and extended ext data
    output periph_pkg::word_t        rdata_o
);
    import periph_pkg::*;

    word_t rd_mux;   // Address phase selection
    word_t rdata_q;

    // ==============================
    // Source select
    // ==============================
    always_comb begin
        rd_mux = '0;
        if (rd_hit_i) begin
            case (rd_slot_i)
                SLOT_I2C:     rd_mux = i2c_sample_i;
                SLOT_GPIO:    rd_mux = gpio_sample_i;
                SLOT_SPI:     rd_mux = spi_sample_i;
                SLOT_COUNTER: rd_mux = counter_i;
                SLOT_EXT:     rd_mux = ext_rdata_i;
                default:      rd_mux = '0;         // UART slots and holes
            endcase
        end
    end

    // Data phase register one cycle after the address
    always_ff @(posedge clk_i or posedge cpu_rst) begin
        if (cpu_rst) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= rd_mux;
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: source/periph_subsys.sv
// Memory-mapped peripheral subsystem at 0x800000xx
// Pads are split into input, output and enable; the board adds the tristate buffers
// GPIO direction and open-drain masks are fixed by parameter
`timescale 1ns/1ns

module periph_subsys #(
    parameter int                    GPIO_WIDTH    = 4,
    parameter logic [GPIO_WIDTH-1:0] GPIO_DIR_MASK = 3,  // 1 = output
    parameter logic [GPIO_WIDTH-1:0] GPIO_OD_MASK  = 2,  // 1 = open drain
    parameter logic [GPIO_WIDTH-1:0] GPIO_WR_RESET = 2   // Output value after reset
) (
    input  logic                  clk_i,
    input  logic                  cpu_rst,
    // Bus master, address phase
    input  periph_pkg::word_t     addr_i,
    input  periph_pkg::word_t     wdata_i,
    input  logic                  wr_en_i,
    input  logic [2:0]            funct3_i,
    output periph_pkg::word_t     rdata_o,      // One cycle after address
    // External byte-lane window
    input  periph_pkg::word_t     ext_rddata_i,
    output periph_pkg::word_t     ext_wdata_o,
    output logic [3:0]            ext_strb_o,
    output logic                  ext_sel_o,
    output logic [3:0]            ext_addr_o,
    // Pads
    input  logic [GPIO_WIDTH-1:0] gpio_i,
    output logic [GPIO_WIDTH-1:0] gpio_o,
    output logic [GPIO_WIDTH-1:0] gpio_oe_o,
    input  logic                  scl_i,
    input  logic                  sda_i,
    output logic                  scl_oe_o,
    output logic                  sda_oe_o,
    input  logic                  miso_i,
    output logic                  sck_o,
    output logic                  mosi_o
);
    import periph_pkg::*;

    periph_slot_e          rd_slot;
    logic                  rd_hit;
    logic                  i2c_wr, gpio_wr, spi_wr, counter_wr;
    word_t                 counter;
    word_t                 gpio_sample, i2c_sample, spi_sample;
    word_t                 ext_rdata;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic [1:0]            i2c_out;
    logic [2:0]            spi_out;

    periph_decode u_decode (
        .addr_i(addr_i), .wr_en_i(wr_en_i), .rd_slot_o(rd_slot), .rd_hit_o(rd_hit),
        .ext_sel_o(ext_sel_o), .ext_addr_o(ext_addr_o), .i2c_wr_o(i2c_wr),
        .gpio_wr_o(gpio_wr), .spi_wr_o(spi_wr), .counter_wr_o(counter_wr)
    );

    free_counter u_counter (
        .clk_i(clk_i), .cpu_rst(cpu_rst), .load_i(counter_wr),
        .load_value_i(wdata_i), .count_o(counter)
    );

    pin_ctrl_regs #(.GPIO_WIDTH(GPIO_WIDTH), .GPIO_WR_RESET(GPIO_WR_RESET)) u_pin_regs (
        .clk_i(clk_i), .cpu_rst(cpu_rst), .wdata_i(wdata_i), .gpio_wr_i(gpio_wr),
        .i2c_wr_i(i2c_wr), .spi_wr_i(spi_wr), .gpio_out_o(gpio_out),
        .i2c_out_o(i2c_out), .spi_out_o(spi_out)
    );

    pin_drive #(
        .GPIO_WIDTH(GPIO_WIDTH), .GPIO_DIR_MASK(GPIO_DIR_MASK), .GPIO_OD_MASK(GPIO_OD_MASK)
    ) u_pin_drive (
        .clk_i(clk_i), .cpu_rst(cpu_rst), .gpio_out_i(gpio_out), .i2c_out_i(i2c_out),
        .spi_out_i(spi_out), .gpio_i(gpio_i), .scl_i(scl_i), .sda_i(sda_i),
        .miso_i(miso_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o), .scl_oe_o(scl_oe_o),
        .sda_oe_o(sda_oe_o), .sck_o(sck_o), .mosi_o(mosi_o),
        .gpio_sample_o(gpio_sample), .i2c_sample_o(i2c_sample), .spi_sample_o(spi_sample)
    );

    ext_bus_align u_ext_align (
        .addr_lo_i(addr_i[1:0]), .funct3_i(funct3_i), .wdata_i(wdata_i),
        .wr_en_i(wr_en_i), .ext_sel_i(ext_sel_o), .ext_rddata_i(ext_rddata_i),
        .ext_wdata_o(ext_wdata_o), .ext_strb_o(ext_strb_o), .ext_rdata_o(ext_rdata)
    );

    periph_read_path u_read_path (
        .clk_i(clk_i), .cpu_rst(cpu_rst), .rd_slot_i(rd_slot), .rd_hit_i(rd_hit),
        .counter_i(counter), .gpio_sample_i(gpio_sample), .i2c_sample_i(i2c_sample),
        .spi_sample_i(spi_sample), .ext_rdata_i(ext_rdata), .rdata_o(rdata_o)
    );

endmodule

// File: verification/tb_checks.svh
// Testbench helpers, included inside the testbench top module
// Uses the top module's bus signals, clock, LFSR state and check counter
// All bus tasks start and end 2 ns after a rising edge
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ==============================
// Random source
// ==============================
// Galois LFSR, right shift, one step per returned bit
function automatic word_t random_bits(input int nbits);
    word_t value;
    logic  out_bit;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;   // Feedback into tap bits
        end
        value[i] = out_bit;
    end
    return value;
endfunction

// ==============================
// Bus access
// ==============================
task automatic drive_bus(input word_t addr, input word_t data, input logic wr,
                         input logic [2:0] f3);
    addr_i   = addr;
    wdata_i  = data;
    wr_en_i  = wr;
    funct3_i = f3;
endtask

task automatic bus_idle();
    drive_bus(32'h0, 32'h0, 1'b0, F3_WORD);
endtask

// Bounded edge loop, lands just after the edge
task automatic next_cycles(input int n);
    for (int i = 0; i < n; i++) begin
        @(posedge clk_i);
        #DRIVE_DELAY;
    end
endtask

task automatic bus_write(input word_t addr, input word_t data, input logic [2:0] f3);
    drive_bus(addr, data, 1'b1, f3);
    next_cycles(1);                        // Register updated at this edge
    bus_idle();
endtask

task automatic bus_read(input word_t addr, input logic [2:0] f3, output word_t data);
    drive_bus(addr, 32'h0, 1'b0, f3);
    next_cycles(1);
    data = rdata_o;                        // Data phase, one cycle later
    bus_idle();
endtask

// Poll the I2C enables, give up after WAIT_LIMIT cycles
task automatic wait_i2c_enables(input logic [1:0] expected);
    int cycles;
    cycles = 0;
    while ({sda_oe_o, scl_oe_o} !== expected) begin
        if (cycles >= WAIT_LIMIT) begin
            fail_now($sformatf("I2C enables did not reach %b within %0d cycles",
                               expected, WAIT_LIMIT));
        end else begin
            next_cycles(1);
            cycles++;
        end
    end
endtask

// ==============================
// Compare tasks
// ==============================
task automatic check_word(input string name, input word_t got, input word_t exp);
    checks_done++;
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
endtask

task automatic check_strb(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks_done++;
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got 0x%01h expected 0x%01h", name, got, exp));
    end
endtask

task automatic check_pins(input string name, input logic [GPIO_WIDTH-1:0] got,
                          input logic [GPIO_WIDTH-1:0] exp);
    checks_done++;
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

`endif

// File: verification/tb_periph_subsys.sv
// Directed testbench for the peripheral subsystem
// Inputs change 2 ns after the rising edge and outputs are sampled once settled
// Pad model pulls the I2C lines up when released
`timescale 1ns/1ns

module tb_periph_subsys;
    import periph_pkg::*;

    localparam int                    GPIO_WIDTH    = 4;
    localparam logic [GPIO_WIDTH-1:0] GPIO_DIR_MASK = 4'b0011;  // Bits 1:0 outputs
    localparam logic [GPIO_WIDTH-1:0] GPIO_OD_MASK  = 4'b0010;  // Bit 1 open drain
    localparam logic [GPIO_WIDTH-1:0] GPIO_WR_RESET = 4'b0010;
    localparam int                    CLK_PERIOD    = 40;
    localparam int                    DRIVE_DELAY   = 2;
    localparam int                    WAIT_LIMIT    = 16;
    localparam word_t                 LFSR_SEED     = 32'd52;
    localparam word_t                 LFSR_TAPS     = 32'h8020_0003;
    localparam logic [2:0]            F3_WORD       = 3'b010;

    logic clk_i;
    logic cpu_rst;
    word_t addr_i, wdata_i, rdata_o, ext_rddata_i, ext_wdata_o;
    logic wr_en_i;
    logic [2:0] funct3_i;
    logic [3:0] ext_strb_o, ext_addr_o;
    logic ext_sel_o;
    logic [GPIO_WIDTH-1:0] gpio_i, gpio_o, gpio_oe_o;
    logic [GPIO_WIDTH-1:0] gpio_stim;     // Level on undriven GPIO pads
    logic scl_i, sda_i, scl_oe_o, sda_oe_o;
    logic miso_i, miso_stim, sck_o, mosi_o;
    word_t lfsr_state;
    int checks_done;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ==============================
    // Pad model
    // ==============================
    assign gpio_i = (gpio_oe_o & gpio_o) | (~gpio_oe_o & gpio_stim);
    assign scl_i  = scl_oe_o ? 1'b0 : 1'b1;   // Pull-up when released
    assign sda_i  = sda_oe_o ? 1'b0 : 1'b1;
    assign miso_i = miso_stim;

    periph_subsys #(
        .GPIO_WIDTH(GPIO_WIDTH), .GPIO_DIR_MASK(GPIO_DIR_MASK),
        .GPIO_OD_MASK(GPIO_OD_MASK), .GPIO_WR_RESET(GPIO_WR_RESET)
    ) periph_subsys_inst (
        .clk_i(clk_i), .cpu_rst(cpu_rst), .addr_i(addr_i), .wdata_i(wdata_i),
        .wr_en_i(wr_en_i), .funct3_i(funct3_i), .rdata_o(rdata_o),
        .ext_rddata_i(ext_rddata_i), .ext_wdata_o(ext_wdata_o), .ext_strb_o(ext_strb_o),
        .ext_sel_o(ext_sel_o), .ext_addr_o(ext_addr_o), .gpio_i(gpio_i), .gpio_o(gpio_o),
        .gpio_oe_o(gpio_oe_o), .scl_i(scl_i), .sda_i(sda_i), .scl_oe_o(scl_oe_o),
        .sda_oe_o(sda_oe_o), .miso_i(miso_i), .sck_o(sck_o), .mosi_o(mosi_o)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    `include "tb_checks.svh"

    function automatic word_t slot_addr(input logic [3:0] slot, input logic [3:0] offset);
        return PERIPH_WIN_BASE | {24'h0, slot, offset};
    endfunction

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_reset_state();
        word_t data;
        check_pins("gpio_o", gpio_o, GPIO_WR_RESET);
        check_word("i2c enables", {30'b0, sda_oe_o, scl_oe_o}, '0);
        check_strb("ext_strb_o", ext_strb_o, 4'b0000);
        bus_read(slot_addr(SLOT_UART0, 4'h0), F3_WORD, data);
        check_word("rdata_o uart0", data, '0);
        bus_read(slot_addr(SLOT_UART1, 4'h0), F3_WORD, data);
        check_word("rdata_o uart1", data, '0);
        bus_read(slot_addr(4'd6, 4'h0), F3_WORD, data);
        check_word("rdata_o slot6", data, '0);
        bus_read(32'h4000_0050, F3_WORD, data);                 // Counter slot outside window
        check_word("rdata_o miss", data, '0);
        bus_read(slot_addr(SLOT_COUNTER, 4'h4), F3_WORD, data); // Unmapped register offset
        check_word("rdata_o offset", data, '0);
    endtask

    task automatic test_gpio();
        word_t rnd, data;
        logic [GPIO_WIDTH-1:0] wr_val, exp_oe, exp_pad;
        for (int iter = 0; iter < 8; iter++) begin
            rnd       = random_bits(GPIO_WIDTH);
            wr_val    = rnd[GPIO_WIDTH-1:0];
            rnd       = random_bits(GPIO_WIDTH);
            gpio_stim = rnd[GPIO_WIDTH-1:0];
            for (int b = 0; b < GPIO_WIDTH; b++) begin
                // Output bit where open drain only pulls low
                exp_oe[b]  = GPIO_DIR_MASK[b] && !(GPIO_OD_MASK[b] && wr_val[b]);
                exp_pad[b] = exp_oe[b] ? wr_val[b] : gpio_stim[b];
            end
            bus_write(slot_addr(SLOT_GPIO, 4'h0), word_t'(wr_val), F3_WORD);
            next_cycles(2);                                      // Pads settle
            check_pins("gpio_o", gpio_o, wr_val);
            check_pins("gpio_oe_o", gpio_oe_o, exp_oe);
            bus_read(slot_addr(SLOT_GPIO, 4'h0), F3_WORD, data);
            check_word("rdata_o gpio", data, word_t'(exp_pad));
        end
    endtask

    task automatic test_i2c_spi();
        word_t rnd, data;
        logic [1:0] i2c_val;
        logic [2:0] spi_val;
        for (int v = 0; v < 4; v++) begin
            i2c_val = v[1:0];                                    // {sda, scl}
            bus_write(slot_addr(SLOT_I2C, 4'h0), word_t'(i2c_val), F3_WORD);
            wait_i2c_enables(~i2c_val);                          // Enable where 0
            next_cycles(2);
            bus_read(slot_addr(SLOT_I2C, 4'h0), F3_WORD, data);
            check_word("rdata_o i2c", data, word_t'(i2c_val));   // Released reads 1
        end
        for (int iter = 0; iter < 6; iter++) begin
            rnd       = random_bits(3);
            spi_val   = rnd[2:0];
            rnd       = random_bits(1);
            miso_stim = rnd[0];
            bus_write(slot_addr(SLOT_SPI, 4'h0), word_t'(spi_val), F3_WORD);
            next_cycles(2);
            check_word("sck_o mosi_o", {30'b0, sck_o, mosi_o}, {30'b0, spi_val[2:1]});
            bus_read(slot_addr(SLOT_SPI, 4'h0), F3_WORD, data);
            check_word("rdata_o spi", data, {29'b0, spi_val[2:1], miso_stim});
        end
    endtask

    // Load x and read with the address cycle k after the write
    task automatic counter_case(input word_t x, input int k);
        word_t data;
        bus_write(slot_addr(SLOT_COUNTER, 4'h0), x, F3_WORD);
        next_cycles(k - 1);
        bus_read(slot_addr(SLOT_COUNTER, 4'h0), F3_WORD, data);
        check_word("rdata_o counter", data, x + word_t'(k - 1));
    endtask

    task automatic test_counter();
        for (int i = 0; i < 4; i++) begin
            counter_case(random_bits(32), 1 + 3 * i);           // k of 1, 4, 7, 10
        end
        counter_case(32'hFFFF_FFFF, 3);                         // Wraps through 0
    endtask

    task automatic test_ext_writes();
        word_t data, exp_wdata;
        logic [3:0] exp_strb;
        logic [2:0] f3;
        for (int sz = 0; sz < 3; sz++) begin
            for (int off = 0; off < 4; off++) begin
                data = random_bits(32);
                f3   = {1'b0, sz[1:0]};
                for (int lane = 0; lane < 4; lane++) begin
                    case (sz)
                        0:       exp_strb[lane] = (lane == off);
                        1:       exp_strb[lane] = (off % 2 == 0) && (lane == off || lane == off + 1);
                        default: exp_strb[lane] = 1'b1;
                    endcase
                    exp_wdata[8*lane +: 8] = (lane >= off) ? data[8*(lane-off) +: 8] : 8'h00;
                end
                drive_bus(slot_addr(SLOT_EXT, off[3:0]), data, 1'b1, f3);
                #1;
                check_strb("ext_strb_o", ext_strb_o, exp_strb);
                check_word("ext_wdata_o", ext_wdata_o, exp_wdata);
                check_strb("ext_addr_o", ext_addr_o, off[3:0]);
                check_strb("ext_sel_o", {3'b0, ext_sel_o}, 4'b0001);
                drive_bus(slot_addr(4'd6, off[3:0]), data, 1'b1, f3);
                #1;
                check_strb("ext_strb_o slot6", ext_strb_o, 4'b0000);
                drive_bus(32'h9000_0070 | off, data, 1'b1, f3);
                #1;
                check_strb("ext_strb_o miss", ext_strb_o, 4'b0000);
                drive_bus(slot_addr(SLOT_EXT, off[3:0]), data, 1'b0, f3);
                #1;
                check_strb("ext_strb_o read", ext_strb_o, 4'b0000);
                next_cycles(1);
                bus_idle();
            end
        end
    endtask

    task automatic test_ext_reads();
        word_t rnd, shifted, exp, data;
        for (int sz = 0; sz < 3; sz++) begin
            for (int off = 0; off < 4; off++) begin
                for (int uns = 0; uns < 2; uns++) begin
                    rnd          = random_bits(32);
                    ext_rddata_i = rnd;
                    // Addressed lane moves to bit 0 and upper lanes fill with 0
                    for (int lane = 0; lane < 4; lane++) begin
                        shifted[8*lane +: 8] = (lane + off <= 3) ? rnd[8*(lane+off) +: 8] : 8'h00;
                    end
                    case (sz)
                        0:       exp = {{24{uns == 0 && shifted[7]}}, shifted[7:0]};
                        1:       exp = {{16{uns == 0 && shifted[15]}}, shifted[15:0]};
                        default: exp = shifted;
                    endcase
                    bus_read(slot_addr(SLOT_EXT, off[3:0]), {uns[0], sz[1:0]}, data);
                    check_word("rdata_o ext", data, exp);
                end
            end
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        lfsr_state   = LFSR_SEED;
        checks_done  = 0;
        clk_i        = 1'b0;
        cpu_rst      = 1'b1;
        ext_rddata_i = '0;
        gpio_stim    = '0;
        miso_stim    = 1'b0;
        bus_idle();
        next_cycles(4);                                          // Reset for 4 cycles
        cpu_rst = 1'b0;
        test_reset_state();
        test_gpio();
        test_i2c_spi();
        test_counter();
        test_ext_writes();
        test_ext_reads();
        if (checks_done > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_now("No checks were executed");
        end
    end

endmodule
